/* all.f */
+incdir+logic
logic/overlay_pkg.sv
logic/video_if.sv
logic/pixel_locator.sv
logic/box_regfile.sv
logic/box_overlay.sv
logic/box_overlay_top.sv
testbench/tb_box_overlay.sv

/* testbench/tb_box_overlay.sv */
`timescale 1ns/1ps

`include "overlay_defs.svh"

module tb_box_overlay
    import overlay_pkg::*;
;

    localparam int H_ACT   = 64;
    localparam int H_TOT   = 80;
    localparam int HS_BEG  = 68;
    localparam int HS_END  = 76;
    localparam int V_BLANK = 4;                 // blank lines before active video
    localparam int V_TOT   = 20;
    localparam int VS_BEG  = 2;
    localparam int VS_END  = 4;
    localparam int FRAME_CYC = H_TOT * V_TOT;
    localparam int N_FRAMES  = 7;
    localparam int TIMEOUT   = (N_FRAMES + 1) * FRAME_CYC + 16 + 100;

    typedef struct packed {
        logic [`OVL_IDX_W-1:0] idx;
        logic [1:0]            sel;
        logic [31:0]           data;
    } cfg_wr_t;

    logic                  clk;
    logic                  arst_n;
    logic                  hsync, vsync, de;
    logic [7:0]            r, g, b;
    logic                  cfg_we;
    logic [`OVL_IDX_W-1:0] cfg_idx;
    logic [1:0]            cfg_sel;
    logic [31:0]           cfg_data;
    logic                  o_hsync, o_vsync, o_de;
    logic [7:0]            o_r, o_g, o_b;

    // reference model state
    box_t        m_shadow [`OVL_N_BOX];
    box_t        m_live   [`OVL_N_BOX];
    cfg_wr_t     cfg_q [$];
    int          mx, my;
    logic        prev_vs, prev_de, commit_pend, cfg_hold;
    logic [26:0] exp_now, exp_d1, exp_d2;       // {hsync, vsync, de, rgb}
    integer      seed = 78;
    int          errors, tests, err_mark, boxed, cycles;

    box_overlay_top box_overlay_top_inst (
        .clk (clk), .i_arst_n (arst_n),
        .i_hsync (hsync), .i_vsync (vsync), .i_de (de),
        .i_r (r), .i_g (g), .i_b (b),
        .i_cfg_we (cfg_we), .i_cfg_idx (cfg_idx), .i_cfg_sel (cfg_sel), .i_cfg_data (cfg_data),
        .o_hsync (o_hsync), .o_vsync (o_vsync), .o_de (o_de),
        .o_r (o_r), .o_g (o_g), .o_b (o_b)
    );

    always #5 clk = ~clk;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_d1 <= '0;
            exp_d2 <= '0;
        end else begin
            exp_d1 <= exp_now;
            exp_d2 <= exp_d1;                   // two cycles through the DUT
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_low: assert property (@(negedge clk)
        !arst_n |-> ({o_hsync, o_vsync, o_de, o_r, o_g, o_b} == '0))
        else begin
            $display("** Error at %0t: outputs not low during reset", $time);
            errors++;
        end

    a_sync: assert property (@(posedge clk) disable iff (!arst_n)
        {o_hsync, o_vsync, o_de} == exp_d2[26:24])
        else begin
            $display("** Error at %0t: hsync/vsync/de %b, expected %b", $time,
                     $sampled({o_hsync, o_vsync, o_de}), $sampled(exp_d2[26:24]));
            errors++;
        end

    a_pix: assert property (@(posedge clk) disable iff (!arst_n)
        {o_r, o_g, o_b} == exp_d2[23:0])
        else begin
            $display("** Error at %0t: pixel %h, expected %h", $time,
                     $sampled({o_r, o_g, o_b}), $sampled(exp_d2[23:0]));
            errors++;
        end

    function automatic logic [23:0] overlay_ref(input logic [23:0] pix, input int x,
                                                input int y, input logic act);
        logic [23:0] c;
        int          bw;
        c  = pix;
        bw = `OVL_BORDER;
        if (act) begin
            for (int i = 0; i < `OVL_N_BOX; i++) begin
                if (m_live[i].enable &&
                    x >= int'(m_live[i].x0) && x <= int'(m_live[i].x1) &&
                    y >= int'(m_live[i].y0) && y <= int'(m_live[i].y1) &&
                    !(x >= int'(m_live[i].x0) + bw && x <= int'(m_live[i].x1) - bw &&
                      y >= int'(m_live[i].y0) + bw && y <= int'(m_live[i].y1) - bw))
                    c = m_live[i].color;        // higher index wins
            end
        end
        return c;
    endfunction

    task automatic apply_write(input cfg_wr_t w);
        case (w.sel)
            FLD_START: begin
                m_shadow[w.idx].x0 = w.data[`OVL_X_W-1:0];
                m_shadow[w.idx].y0 = w.data[16 +: `OVL_Y_W];
            end
            FLD_END: begin
                m_shadow[w.idx].x1 = w.data[`OVL_X_W-1:0];
                m_shadow[w.idx].y1 = w.data[16 +: `OVL_Y_W];
            end
            FLD_COLOR:  m_shadow[w.idx].color  = w.data[23:0];
            default:    m_shadow[w.idx].enable = w.data[0];
        endcase
    endtask

    task automatic queue_write(input int idx, input cfg_field_e sel, input logic [31:0] data);
        cfg_wr_t w;
        w.idx  = idx;
        w.sel  = sel;
        w.data = data;
        cfg_q.push_back(w);
    endtask

    task automatic drive_step(input logic hs, input logic vs, input logic act);
        cfg_wr_t     w;
        logic        wr;
        logic [31:0] rnd;
        logic [23:0] pix;
        @(negedge clk);
        wr = 1'b0;
        w  = '0;
        if (commit_pend) begin
            for (int i = 0; i < `OVL_N_BOX; i++)
                m_live[i] = m_shadow[i];
            commit_pend = 1'b0;
        end
        if (!cfg_hold && cfg_q.size() > 0) begin
            w  = cfg_q.pop_front();
            wr = 1'b1;
        end
        rnd = $random(seed);
        pix = rnd[23:0];
        if (vs && !prev_vs)
            my = 0;
        else if (prev_de && !act)
            my++;
        mx = (act && prev_de) ? mx + 1 : 0;
        exp_now = {hs, vs, act, overlay_ref(pix, mx, my, act)};
        if (exp_now[23:0] != pix)
            boxed++;
        {hsync, vsync, de} = {hs, vs, act};
        {r, g, b} = pix;
        {cfg_we, cfg_idx, cfg_sel, cfg_data} = {wr, w.idx, w.sel, w.data};
        if (wr)
            apply_write(w);                     // commit above saw the older shadow
        if (vs && !prev_vs)
            commit_pend = 1'b1;
        prev_vs = vs;
        prev_de = act;
    endtask

    // writes held back until line rel_line when rel_line > 0
    task automatic run_frame(input int rel_line);
        cfg_hold = (rel_line > 0);
        for (int l = 0; l < V_TOT; l++) begin
            if (l == rel_line)
                cfg_hold = 1'b0;
            for (int c = 0; c < H_TOT; c++)
                drive_step(c >= HS_BEG && c < HS_END, l >= VS_BEG && l < VS_END,
                           l >= V_BLANK && c < H_ACT);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s, %0d errors, %0d pixels boxed", tests, name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark, boxed);
        err_mark = errors;
        boxed    = 0;
    endtask

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        {hsync, vsync, de, r, g, b} = '0;
        {cfg_we, cfg_idx, cfg_sel, cfg_data} = '0;
        for (int i = 0; i < `OVL_N_BOX; i++) begin
            m_shadow[i] = '0;
            m_live[i]   = '0;
        end
        {mx, my, errors, tests, err_mark, boxed, cycles} = '0;
        {prev_vs, prev_de, commit_pend, cfg_hold} = '0;
        exp_now = '0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        run_frame(0);
        finish_test("reset and pass-through");

        queue_write(0, FLD_START,  (3 << 16) | 5);
        queue_write(0, FLD_END,    (10 << 16) | 20);
        queue_write(0, FLD_COLOR,  32'h00ff0000);
        queue_write(0, FLD_ENABLE, 32'd1);
        run_frame(0);
        finish_test("single box border");

        queue_write(0, FLD_ENABLE, 32'd0);
        queue_write(1, FLD_START,  (2 << 16) | 10);
        queue_write(1, FLD_END,    (12 << 16) | 40);
        queue_write(1, FLD_COLOR,  32'h0000ff00);
        queue_write(1, FLD_ENABLE, 32'd1);
        queue_write(2, FLD_START,  (6 << 16) | 30);
        queue_write(2, FLD_END,    (14 << 16) | 60);
        queue_write(2, FLD_COLOR,  32'h000000ff);
        queue_write(2, FLD_ENABLE, 32'd1);
        run_frame(0);
        finish_test("overlap priority");

        queue_write(3, FLD_START,  32'd0);      // whole active area
        queue_write(3, FLD_END,    (15 << 16) | 63);
        queue_write(3, FLD_COLOR,  32'h00808080);
        queue_write(3, FLD_ENABLE, 32'd1);
        run_frame(V_BLANK + 8);
        run_frame(0);
        finish_test("frame-boundary commit");

        run_frame(0);                           // x sits at 0 in blanking, on box 3
        finish_test("blanking untouched");

        queue_write(3, FLD_ENABLE, 32'd0);
        queue_write(1, FLD_ENABLE, 32'd0);
        run_frame(0);
        repeat (4) drive_step(1'b0, 1'b0, 1'b0);
        finish_test("disable");

        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule : tb_box_overlay

/* logic/box_overlay_top.sv */
`timescale 1ns/1ps

`include "overlay_defs.svh"

module box_overlay_top
    import overlay_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_hsync,
    input  logic                   i_vsync,
    input  logic                   i_de,
    input  logic [7:0]             i_r,
    input  logic [7:0]             i_g,
    input  logic [7:0]             i_b,
    input  logic                   i_cfg_we,
    input  logic [`OVL_IDX_W-1:0]  i_cfg_idx,
    input  logic [1:0]             i_cfg_sel,
    input  logic [31:0]            i_cfg_data,
    output logic                   o_hsync,
    output logic                   o_vsync,
    output logic                   o_de,
    output logic [7:0]             o_r,
    output logic [7:0]             o_g,
    output logic [7:0]             o_b
);

    rgb_t                  in_pix;
    rgb_t                  out_pix;
    logic                  frame_start;
    box_t [`OVL_N_BOX-1:0] boxes;

    video_if vid_if ();

    assign in_pix = '{r: i_r, g: i_g, b: i_b};

    pixel_locator pixel_locator_inst (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_hsync       (i_hsync),
        .i_vsync       (i_vsync),
        .i_de          (i_de),
        .i_pix         (in_pix),
        .o_frame_start (frame_start),
        .vid           (vid_if.src)
    );

    box_regfile box_regfile_inst (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_cfg_we      (i_cfg_we),
        .i_cfg_idx     (i_cfg_idx),
        .i_cfg_sel     (cfg_field_e'(i_cfg_sel)),
        .i_cfg_data    (i_cfg_data),
        .i_frame_start (frame_start),
        .o_boxes       (boxes)
    );

    box_overlay box_overlay_inst (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .vid           (vid_if.snk),
        .i_boxes       (boxes),
        .o_hsync       (o_hsync),
        .o_vsync       (o_vsync),
        .o_de          (o_de),
        .o_pix         (out_pix)
    );

    assign o_r = out_pix.r;
    assign o_g = out_pix.g;
    assign o_b = out_pix.b;

endmodule : box_overlay_top

/* logic/box_overlay.sv */
`timescale 1ns/1ps

`include "overlay_defs.svh"

module box_overlay
    import overlay_pkg::*;
(
    input  logic                        clk,
    input  logic                        i_arst_n,
    video_if.snk                        vid,
    input  box_t [`OVL_N_BOX-1:0]       i_boxes,
    output logic                        o_hsync,
    output logic                        o_vsync,
    output logic                        o_de,
    output rgb_t                        o_pix
);

    logic [`OVL_N_BOX-1:0] hit;
    rgb_t                  pix_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // border test per box
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar gi = 0; gi < `OVL_N_BOX; gi++) begin : g_box
        box_t b;
        logic outer_in;
        logic inner_in;

        assign b = i_boxes[gi];

        assign outer_in = (vid.x >= b.x0) && (vid.x <= b.x1) &&
                          (vid.y >= b.y0) && (vid.y <= b.y1);

        // 32-bit compare context, so no wrap near the frame edges
        assign inner_in = (vid.x >= b.x0 + `OVL_BORDER) &&
                          (vid.x + `OVL_BORDER <= b.x1) &&
                          (vid.y >= b.y0 + `OVL_BORDER) &&
                          (vid.y + `OVL_BORDER <= b.y1);

        assign hit[gi] = b.enable && outer_in && !inner_in;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority select, highest index last
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pix_d = vid.pix;
        if (vid.de) begin
            for (int i = 0; i < `OVL_N_BOX; i++) begin
                if (hit[i])
                    pix_d = i_boxes[i].color;   // later box overrides
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
            o_pix   <= '0;
        end else begin
            o_hsync <= vid.hsync;
            o_vsync <= vid.vsync;
            o_de    <= vid.de;
            o_pix   <= pix_d;
        end
    end

    // blanking pixels leave untouched
    a_blank_pass: assert property (@(posedge clk) disable iff (!i_arst_n)
        !vid.de |=> (o_pix == $past(vid.pix)))
        else $error("box_overlay: blanking pixel was modified");

endmodule : box_overlay

/* logic/box_regfile.sv */
`timescale 1ns/1ps

`include "overlay_defs.svh"

module box_regfile
    import overlay_pkg::*;
(
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_cfg_we,
    input  logic [`OVL_IDX_W-1:0]       i_cfg_idx,
    input  cfg_field_e                  i_cfg_sel,
    input  logic [31:0]                 i_cfg_data,
    input  logic                        i_frame_start,
    output box_t [`OVL_N_BOX-1:0]       o_boxes
);

    box_t [`OVL_N_BOX-1:0] shadow_q;            // written by config
    box_t [`OVL_N_BOX-1:0] live_q;              // seen by the overlay

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shadow table, one field per write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shadow_q <= '0;
        end else if (i_cfg_we) begin
            case (i_cfg_sel)
                FLD_START: begin
                    shadow_q[i_cfg_idx].x0 <= i_cfg_data[`OVL_X_W-1:0];
                    shadow_q[i_cfg_idx].y0 <= i_cfg_data[16 +: `OVL_Y_W];
                end
                FLD_END: begin
                    shadow_q[i_cfg_idx].x1 <= i_cfg_data[`OVL_X_W-1:0];
                    shadow_q[i_cfg_idx].y1 <= i_cfg_data[16 +: `OVL_Y_W];
                end
                FLD_COLOR: begin
                    shadow_q[i_cfg_idx].color <= rgb_t'(i_cfg_data[23:0]);
                end
                FLD_ENABLE: begin
                    shadow_q[i_cfg_idx].enable <= i_cfg_data[0];
                end
                default: begin
                    shadow_q <= shadow_q;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commit at frame start
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n)
            live_q <= '0;
        else if (i_frame_start)
            live_q <= shadow_q;                 // same-cycle write waits a frame
    end

    assign o_boxes = live_q;

    a_idx_range: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_cfg_we |-> (i_cfg_idx < `OVL_N_BOX))
        else $error("box_regfile: write to box %0d beyond table", i_cfg_idx);

    a_sel_known: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_cfg_we |-> !$isunknown(i_cfg_sel))
        else $error("box_regfile: field select unknown during write");

endmodule : box_regfile

/* logic/pixel_locator.sv */
`timescale 1ns/1ps

`include "overlay_defs.svh"

module pixel_locator
    import overlay_pkg::*;
(
    input  logic  clk,
    input  logic  i_arst_n,
    input  logic  i_hsync,
    input  logic  i_vsync,
    input  logic  i_de,
    input  rgb_t  i_pix,
    output logic  o_frame_start,
    video_if.src  vid
);

    logic     hsync_q;
    logic     vsync_q;
    logic     de_q;
    rgb_t     pix_q;
    coord_x_t x_q;
    coord_y_t y_q;
    logic     frame_start_q;

    logic     vsync_rise;
    logic     de_fall;

    assign vsync_rise = i_vsync && !vsync_q;
    assign de_fall    = de_q && !i_de;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hsync_q       <= 1'b0;
            vsync_q       <= 1'b0;
            de_q          <= 1'b0;
            pix_q         <= '0;
            x_q           <= '0;
            y_q           <= '0;
            frame_start_q <= 1'b0;
        end else begin
            hsync_q       <= i_hsync;
            vsync_q       <= i_vsync;
            de_q          <= i_de;
            pix_q         <= i_pix;
            frame_start_q <= vsync_rise;        // lines up with vid.vsync edge
            x_q           <= (i_de && de_q) ? x_q + 1'b1 : '0;
            if (vsync_rise)
                y_q <= '0;
            else if (de_fall)
                y_q <= y_q + 1'b1;              // next line
        end
    end

    assign vid.hsync     = hsync_q;
    assign vid.vsync     = vsync_q;
    assign vid.de        = de_q;
    assign vid.pix       = pix_q;
    assign vid.x         = x_q;
    assign vid.y         = y_q;
    assign o_frame_start = frame_start_q;

    // counters must stay inside the active window while pixels are valid
    a_coord_range: assert property (@(posedge clk) disable iff (!i_arst_n)
        de_q |-> (x_q < `OVL_H_ACT) && (y_q < `OVL_V_ACT))
        else $error("pixel_locator: coordinate out of range x=%0d y=%0d", x_q, y_q);

endmodule : pixel_locator

/* logic/video_if.sv */
`timescale 1ns/1ps

interface video_if
    import overlay_pkg::*;
;

    logic     hsync;
    logic     vsync;
    logic     de;
    coord_x_t x;                                // valid only while de
    coord_y_t y;
    rgb_t     pix;

    modport src (
        output hsync, vsync, de, x, y, pix
    );

    modport snk (
        input  hsync, vsync, de, x, y, pix
    );

endinterface : video_if

/* logic/overlay_pkg.sv */
package overlay_pkg;

    `include "overlay_defs.svh"

    typedef logic [`OVL_X_W-1:0] coord_x_t;
    typedef logic [`OVL_Y_W-1:0] coord_y_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // one outline entry, corners inclusive
    typedef struct packed {
        logic     enable;
        coord_x_t x0;
        coord_x_t x1;
        coord_y_t y0;
        coord_y_t y1;
        rgb_t     color;
    } box_t;

    typedef enum logic [1:0] {
        FLD_START  = 2'd0,                      // x0 / y0
        FLD_END    = 2'd1,                      // x1 / y1
        FLD_COLOR  = 2'd2,
        FLD_ENABLE = 2'd3
    } cfg_field_e;

endpackage : overlay_pkg

/* logic/overlay_defs.svh */
`ifndef OVERLAY_DEFS_SVH
`define OVERLAY_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// active frame geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define OVL_H_ACT   1280                        // pixels per line
`define OVL_V_ACT   720                         // lines per frame
`define OVL_X_W     ($clog2(`OVL_H_ACT))
`define OVL_Y_W     ($clog2(`OVL_V_ACT))

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// box table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define OVL_N_BOX   4
`define OVL_IDX_W   ((`OVL_N_BOX > 1) ? $clog2(`OVL_N_BOX) : 1)
`define OVL_BORDER  1                           // outline thickness

`endif
